// File: list.f
verilog/audio_types_pkg.sv
verilog/compress_pkg.sv
verilog/audio_mixer.sv
verilog/compressor_lane.sv
verilog/stereo_output.sv
verilog/audio_post.sv
sim/tb_audio_post.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= tb_audio_post
RTL_TOP   ?= audio_post
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "Testbench reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "Simulation passed" $(LOG); then \
		echo "Run ended without a pass line, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tb_audio_post.sv
// Testbench for the audio post path: directed tests against a reference model
module tb_audio_post;
	timeunit 1ns;
	timeprecision 100ps;
	import audio_types_pkg::*;
	import compress_pkg::*;

	// 46 single samples at about 7 cycles and 216 streamed, with wide margin
	localparam int MAX_CYCLES = 20000;
	localparam int LATENCY    = 5; // Edges from acceptance to out_valid, inclusive

	logic        clk_sys;
	logic        reset;
	logic        in_valid;
	logic        in_ready;
	src_sample_t cdda_l;
	src_sample_t cdda_r;
	src_sample_t psg_l;
	src_sample_t psg_r;
	src_sample_t adpcm;
	logic        cd_boost;
	comp_mode_t  comp_mode;
	logic        out_valid;
	logic        out_ready;
	level_t      audio_l;
	level_t      audio_r;

	integer seed = 27782;
	int     cycles = 0;
	int     errors = 0;
	int     checks = 0;
	int     received = 0;
	bit     bp_running = 0;
	bit     waiting = 0;
	level_t held_l;
	level_t held_r;
	level_t exp_l[$];
	level_t exp_r[$];

	audio_post uut (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.cdda_l    (cdda_l),
		.cdda_r    (cdda_r),
		.psg_l     (psg_l),
		.psg_r     (psg_r),
		.adpcm     (adpcm),
		.cd_boost  (cd_boost),
		.comp_mode (comp_mode),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.audio_l   (audio_l),
		.audio_r   (audio_r)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: no finish after %0d cycles", MAX_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////

	function automatic int wrap18(int x);
		int w;
		w = x & 32'h3FFFF;
		if (w >= 131072)
			w = w - 262144; // Back to signed
		return w;
	endfunction

	function automatic level_t expected_level(int cd, int psg, int voice, logic boost,
			comp_mode_t mode);
		int sum;
		int lvl;
		int mag;
		int res;
		int knee;
		int gain;
		int slope;
		int base;
		sum = wrap18(cd + (boost ? cd : 0) + psg + voice);
		if (!boost)
			sum = wrap18(sum + (sum >>> 2)); // 5/4 stretch
		lvl = (sum >>> 2) & 32'hFFFF;
		if (mode == COMP_OFF)
			return level_t'(lvl);
		knee  = (mode == COMP_SOFT) ? int'(KNEE_SOFT) : int'(KNEE_HARD);
		gain  = (mode == COMP_SOFT) ? int'(GAIN_SOFT) : int'(GAIN_HARD);
		slope = (mode == COMP_SOFT) ? int'(SLOPE_SOFT) : int'(SLOPE_HARD);
		base  = (mode == COMP_SOFT) ? int'(BASE_SOFT) : int'(BASE_HARD);
		mag = (lvl >= 32768) ? ((65536 - lvl) & 32'hFFFF) : lvl;
		res = (mag < knee) ? mag * gain : (mag - knee) / slope + base;
		res = res & 32'hFFFF;
		if (lvl >= 32768)
			res = (65536 - res) & 32'hFFFF;
		return level_t'(res);
	endfunction

	//////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////

	task automatic compare_level(string what, level_t got, level_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_flag(string what, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic compare_count(string what, int got, int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// Output scoreboard plus the hold check while out_valid waits
	always @(posedge clk_sys) begin
		if (reset) begin
			waiting = 1'b0;
		end else begin
			if (waiting) begin
				compare_flag("out_valid while held", out_valid, 1'b1);
				compare_level("audio_l while held", audio_l, held_l);
				compare_level("audio_r while held", audio_r, held_r);
			end
			if (out_valid && out_ready) begin
				if (exp_l.size() == 0) begin
					errors++;
					$display("Output sample at %0t ns with nothing pending", $time);
				end else begin
					compare_level("audio_l", audio_l, exp_l.pop_front());
					compare_level("audio_r", audio_r, exp_r.pop_front());
					received++;
				end
			end
			waiting = out_valid && !out_ready;
			held_l  = audio_l;
			held_r  = audio_r;
		end
	end

	//////////////////////////////////////////////////////////////
	// Drivers
	//////////////////////////////////////////////////////////////

	// Called 1 ns after an edge, returns 1 ns after the accepting edge
	task automatic send_sample(src_sample_t cl, src_sample_t cr, src_sample_t pl,
			src_sample_t pr, src_sample_t ad, logic boost, comp_mode_t mode);
		cdda_l    = cl;
		cdda_r    = cr;
		psg_l     = pl;
		psg_r     = pr;
		adpcm     = ad;
		cd_boost  = boost;
		comp_mode = mode;
		in_valid  = 1'b1;
		@(posedge clk_sys);
		while (!in_ready)
			@(posedge clk_sys);
		exp_l.push_back(expected_level(int'(cl), int'(pl), int'(ad), boost, mode));
		exp_r.push_back(expected_level(int'(cr), int'(pr), int'(ad), boost, mode));
		#1;
		in_valid = 1'b0;
	endtask

	task automatic send_random(logic boost, comp_mode_t mode);
		src_sample_t v[5];
		for (int i = 0; i < 5; i++)
			v[i] = src_sample_t'($random(seed));
		send_sample(v[0], v[1], v[2], v[3], v[4], boost, mode);
	endtask

	task automatic wait_drain();
		while (exp_l.size() != 0) begin
			@(posedge clk_sys);
			#1;
		end
	endtask

	// One isolated sample with latency check
	task automatic run_single(int cl, int cr, int pl, int pr, int ad, logic boost,
			comp_mode_t mode);
		int lat;
		out_ready = 1'b1;
		send_sample(src_sample_t'(cl), src_sample_t'(cr), src_sample_t'(pl),
			src_sample_t'(pr), src_sample_t'(ad), boost, mode);
		lat = 1;
		while (!out_valid) begin
			@(posedge clk_sys);
			#1;
			lat++;
		end
		compare_count("latency in cycles", lat, LATENCY);
		wait_drain();
	endtask

	task automatic report_test(string name, int start_errors);
		$display("Test %s finished, %0d errors", name, errors - start_errors);
	endtask

	//////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////

	task automatic check_reset_state();
		int start;
		start = errors;
		repeat (11) begin
			@(posedge clk_sys);
			#1;
			if (cycles == 10)
				reset = 1'b0; // Ten edges under reset, one after
			compare_flag("out_valid after reset", out_valid, 1'b0);
			compare_flag("in_ready after reset", in_ready, 1'b1);
			compare_level("audio_l after reset", audio_l, '0);
			compare_level("audio_r after reset", audio_r, '0);
		end
		report_test("reset state", start);
	endtask

	task automatic mix_vectors(logic boost);
		run_single(0, 0, 0, 0, 0, boost, COMP_OFF);
		run_single(32767, 32767, 32767, 32767, 32767, boost, COMP_OFF); // Max positive
		run_single(-32768, -32768, -32768, -32768, -32768, boost, COMP_OFF);
		run_single(1000, -2000, -3000, 4000, 123, boost, COMP_OFF);
		run_single(-12345, 23456, 5000, -7000, -100, boost, COMP_OFF);
	endtask

	task automatic plain_mix();
		int start;
		start = errors;
		mix_vectors(1'b0);
		report_test("plain mix", start);
	endtask

	task automatic cd_boost_mix();
		int start;
		start = errors;
		mix_vectors(1'b1);
		report_test("cd boost", start);
	endtask

	// With boost on, cd + cd + psg + adpcm = 4L gives level L exactly
	task automatic compression_curves();
		int start;
		int lv[12] = '{0, 7399, 7400, 7401, 14043, 14044, 14045, 32767,
			-32768, -7401, -14044, -1};
		comp_mode_t modes[3];
		start = errors;
		modes[0] = COMP_SOFT;
		modes[1] = COMP_HARD;
		modes[2] = comp_mode_t'(2'd3);
		foreach (modes[m])
			foreach (lv[i])
				run_single(lv[i], lv[i], lv[i], lv[i], lv[i], 1'b1, modes[m]);
		report_test("compression curves", start);
	endtask

	task automatic back_pressure();
		int start;
		int first;
		int rnd;
		int ready_rnd;
		start = errors;
		first = received;
		bp_running = 1'b1;
		fork
			begin
				for (int n = 0; n < 200; n++) begin
					rnd = $random(seed);
					send_random(rnd[2], comp_mode_t'(rnd[1:0]));
				end
				bp_running = 1'b0;
			end
			begin
				// Draw on the edge, drive just after it
				@(posedge clk_sys);
				while (bp_running) begin
					ready_rnd = $random(seed);
					#1;
					out_ready = ready_rnd[0];
					@(posedge clk_sys);
				end
			end
		join
		#1;
		out_ready = 1'b1;
		wait_drain();
		compare_count("samples received", received - first, 200);
		report_test("back-pressure", start);
	endtask

	task automatic mode_changes();
		int start;
		start = errors;
		out_ready = 1'b1;
		for (int n = 0; n < 16; n++)
			send_random(1'b0, comp_mode_t'(n[1:0])); // OFF, SOFT, HARD, code 3
		wait_drain();
		report_test("mode change", start);
	endtask

	initial begin
		reset     = 1'b1;
		in_valid  = 1'b0;
		cdda_l    = '0;
		cdda_r    = '0;
		psg_l     = '0;
		psg_r     = '0;
		adpcm     = '0;
		cd_boost  = 1'b0;
		comp_mode = COMP_OFF;
		out_ready = 1'b1;
		check_reset_state();
		plain_mix();
		cd_boost_mix();
		compression_curves();
		back_pressure();
		mode_changes();
		$display("Checks: %0d, errors: %0d, samples: %0d", checks, errors, received);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: verilog/audio_post.sv
// Audio post-processing top: source mixer, per-channel compressor lanes, stereo output
module audio_post (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  logic                         in_valid,
	output logic                         in_ready,
	input  audio_types_pkg::src_sample_t cdda_l,
	input  audio_types_pkg::src_sample_t cdda_r,
	input  audio_types_pkg::src_sample_t psg_l,
	input  audio_types_pkg::src_sample_t psg_r,
	input  audio_types_pkg::src_sample_t adpcm,
	input  logic                         cd_boost,
	input  compress_pkg::comp_mode_t     comp_mode,
	output logic                         out_valid,
	input  logic                         out_ready,
	output audio_types_pkg::level_t      audio_l,
	output audio_types_pkg::level_t      audio_r
);
	import audio_types_pkg::*;
	import compress_pkg::*;

	logic                 mix_valid;
	comp_mode_t           mix_mode;
	level_t               mix_level [NUM_LANES];  // Index 0 left, 1 right
	logic [NUM_LANES-1:0] lane_in_ready;
	logic [NUM_LANES-1:0] lane_valid;
	level_t               lane_level [NUM_LANES];
	logic                 lane_ready;

	audio_mixer u_mixer (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.in_valid      (in_valid),
		.in_ready      (in_ready),
		.cdda_l        (cdda_l),
		.cdda_r        (cdda_r),
		.psg_l         (psg_l),
		.psg_r         (psg_r),
		.adpcm         (adpcm),
		.cd_boost      (cd_boost),
		.comp_mode     (comp_mode),
		.mix_valid     (mix_valid),
		.mix_level_l   (mix_level[0]),
		.mix_level_r   (mix_level[1]),
		.mix_mode      (mix_mode),
		.lane_in_ready (lane_in_ready)
	);

	////////////////////////////////////////////////////////////
	// One compressor per channel
	////////////////////////////////////////////////////////////

	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		compressor_lane u_lane (
			.clk_sys   (clk_sys),
			.reset     (reset),
			.in_valid  (mix_valid),
			.in_ready  (lane_in_ready[i]),
			.level     (mix_level[i]),
			.mode      (mix_mode),
			.out_valid (lane_valid[i]),
			.out_ready (lane_ready),
			.result    (lane_level[i])
		);
	end

	stereo_output u_output (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.lane_valid    (lane_valid),
		.lane_result_l (lane_level[0]),
		.lane_result_r (lane_level[1]),
		.lane_ready    (lane_ready),
		.out_valid     (out_valid),
		.out_ready     (out_ready),
		.audio_l       (audio_l),
		.audio_r       (audio_r)
	);

endmodule

// File: verilog/stereo_output.sv
// Stereo output stage: joins both lane results into one valid/ready sample
module stereo_output (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic [audio_types_pkg::NUM_LANES-1:0] lane_valid,
	input  audio_types_pkg::level_t              lane_result_l,
	input  audio_types_pkg::level_t              lane_result_r,
	output logic                                 lane_ready,
	output logic                                 out_valid,
	input  logic                                 out_ready,
	output audio_types_pkg::level_t              audio_l,
	output audio_types_pkg::level_t              audio_r
);
	import audio_types_pkg::*;

	logic all_valid;
	logic slot_free;

	assign all_valid  = &lane_valid;
	assign slot_free  = ~out_valid | out_ready; // Empty or draining this edge

	// Only pull from the lanes when a full stereo pair is present
	assign lane_ready = all_valid & slot_free;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			out_valid <= 1'b0;
			audio_l   <= '0;
			audio_r   <= '0;
		end else begin
			if (slot_free)
				out_valid <= all_valid;
			if (lane_ready) begin
				audio_l <= lane_result_l;
				audio_r <= lane_result_r;
			end
		end
	end

endmodule

// File: verilog/compressor_lane.sv
// Compressor lane: soft-knee compression of one channel level, two stages
module compressor_lane (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  audio_types_pkg::level_t  level,
	input  compress_pkg::comp_mode_t mode,
	output logic                     out_valid,
	input  logic                     out_ready,
	output audio_types_pkg::level_t  result
);
	import audio_types_pkg::*;
	import compress_pkg::*;

	// Linear gain below the knee, flattened slope above it
	function automatic level_t knee_curve(level_t v, level_t knee, level_t gain,
			level_t slope, level_t base);
		if (v < knee)
			return v * gain;
		return (v - knee) / slope + base;
	endfunction

	logic       s1_valid;
	logic       s1_ready;
	logic       s2_ready;
	logic       s1_sign;
	level_t     s1_mag;
	comp_mode_t s1_mode;

	level_t     soft_val;
	level_t     hard_val;
	level_t     curve_val;
	level_t     pass_val;
	level_t     shaped;

	assign s2_ready = ~out_valid | out_ready;
	assign s1_ready = ~s1_valid | s2_ready;
	assign in_ready = s1_ready;

	////////////////////////////////////////////////////////////
	// Stage one, sign and magnitude
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset)
			s1_valid <= 1'b0;
		else if (s1_ready)
			s1_valid <= in_valid;
	end

	always_ff @(posedge clk_sys) begin
		if (in_valid && s1_ready) begin
			s1_sign <= level[15];
			s1_mag  <= level[15] ? -level : level; // 0x8000 keeps its pattern
			s1_mode <= mode;
		end
	end

	////////////////////////////////////////////////////////////
	// Stage two, curve and sign restore
	////////////////////////////////////////////////////////////

	always_comb begin
		soft_val  = knee_curve(s1_mag, KNEE_SOFT, GAIN_SOFT, SLOPE_SOFT, BASE_SOFT);
		hard_val  = knee_curve(s1_mag, KNEE_HARD, GAIN_HARD, SLOPE_HARD, BASE_HARD);
		curve_val = (s1_mode == COMP_SOFT) ? soft_val : hard_val; // Code 3 is hard
		pass_val  = s1_sign ? -s1_mag : s1_mag; // Rebuilds the original level
		if (s1_mode == COMP_OFF)
			shaped = pass_val;
		else
			shaped = s1_sign ? -curve_val : curve_val;
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			out_valid <= 1'b0;
		else if (s2_ready)
			out_valid <= s1_valid;
	end

	always_ff @(posedge clk_sys) begin
		if (s1_valid && s2_ready)
			result <= shaped;
	end

endmodule

// File: verilog/audio_mixer.sv
// Source mixer: sums CD, PSG and ADPCM per channel, then applies the range stretch
module audio_mixer (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 in_valid,
	output logic                                 in_ready,
	input  audio_types_pkg::src_sample_t         cdda_l,
	input  audio_types_pkg::src_sample_t         cdda_r,
	input  audio_types_pkg::src_sample_t         psg_l,
	input  audio_types_pkg::src_sample_t         psg_r,
	input  audio_types_pkg::src_sample_t         adpcm,
	input  logic                                 cd_boost,
	input  compress_pkg::comp_mode_t             comp_mode,
	output logic                                 mix_valid,
	output audio_types_pkg::level_t              mix_level_l,
	output audio_types_pkg::level_t              mix_level_r,
	output compress_pkg::comp_mode_t             mix_mode,
	input  logic [audio_types_pkg::NUM_LANES-1:0] lane_in_ready
);
	import audio_types_pkg::*;
	import compress_pkg::*;

	// CD term counted twice when boosted, ADPCM is shared by both channels
	function automatic mix_sum_t source_sum(src_sample_t cd, src_sample_t psg,
			src_sample_t voice, logic boost);
		mix_sum_t cd_w;
		mix_sum_t extra;
		cd_w = mix_sum_t'(cd);
		extra = boost ? cd_w : mix_sum_t'(0);
		return cd_w + extra + mix_sum_t'(psg) + mix_sum_t'(voice);
	endfunction

	// 5/4 stretch fills the range when the CD is not doubled
	function automatic level_t range_stretch(mix_sum_t sum, logic boost);
		mix_sum_t stretched;
		stretched = boost ? sum : sum + (sum >>> 2);
		return stretched[$bits(mix_sum_t)-1:SUM_GUARD];
	endfunction

	logic       lanes_ready;
	logic       s1_valid;
	logic       s1_ready;
	logic       s2_ready;
	mix_sum_t   s1_sum_l;
	mix_sum_t   s1_sum_r;
	logic       s1_boost;
	comp_mode_t s1_mode;

	assign lanes_ready = &lane_in_ready; // Lanes move in lockstep
	assign s2_ready    = ~mix_valid | lanes_ready;
	assign s1_ready    = ~s1_valid | s2_ready;
	assign in_ready    = s1_ready;

	////////////////////////////////////////////////////////////
	// Stage one, source sums
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset)
			s1_valid <= 1'b0;
		else if (s1_ready)
			s1_valid <= in_valid;
	end

	always_ff @(posedge clk_sys) begin
		if (in_valid && s1_ready) begin
			s1_sum_l <= source_sum(cdda_l, psg_l, adpcm, cd_boost);
			s1_sum_r <= source_sum(cdda_r, psg_r, adpcm, cd_boost);
			s1_boost <= cd_boost; // Controls travel with the sample
			s1_mode  <= comp_mode;
		end
	end

	////////////////////////////////////////////////////////////
	// Stage two, stretch and reduce to 16 bits
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset)
			mix_valid <= 1'b0;
		else if (s2_ready)
			mix_valid <= s1_valid;
	end

	always_ff @(posedge clk_sys) begin
		if (s1_valid && s2_ready) begin
			mix_level_l <= range_stretch(s1_sum_l, s1_boost);
			mix_level_r <= range_stretch(s1_sum_r, s1_boost);
			mix_mode    <= s1_mode;
		end
	end

endmodule

// File: verilog/compress_pkg.sv
// Compression mode encoding and the constants of both soft-knee curves
package compress_pkg;

	////////////////////////////////////////////////////////////
	// Mode
	////////////////////////////////////////////////////////////

	// Code 2'b11 behaves as COMP_HARD, the upper bit picks the curve
	typedef enum logic [1:0] {
		COMP_OFF  = 2'd0, // Level passes through
		COMP_SOFT = 2'd1, // Curve one
		COMP_HARD = 2'd2  // Curve two
	} comp_mode_t;

	////////////////////////////////////////////////////////////
	// Curve one
	////////////////////////////////////////////////////////////

	// Knee sits where the upper segment just reaches full scale
	localparam logic [15:0] KNEE_SOFT  = 16'd14044;
	localparam logic [15:0] GAIN_SOFT  = 16'd2;     // Below the knee
	localparam logic [15:0] SLOPE_SOFT = 16'd4;     // Divisor above the knee
	localparam logic [15:0] BASE_SOFT  = 16'd28088; // KNEE_SOFT * GAIN_SOFT

	////////////////////////////////////////////////////////////
	// Curve two
	////////////////////////////////////////////////////////////

	// Steeper gain, lower knee
	localparam logic [15:0] KNEE_HARD  = 16'd7400;
	localparam logic [15:0] GAIN_HARD  = 16'd4;
	localparam logic [15:0] SLOPE_HARD = 16'd8;
	localparam logic [15:0] BASE_HARD  = 16'd29600; // KNEE_HARD * GAIN_HARD

endpackage

// File: verilog/audio_types_pkg.sv
// Audio path types: source sample, widened sum and channel level widths
package audio_types_pkg;

	////////////////////////////////////////////////////////////
	// Channel structure
	////////////////////////////////////////////////////////////

	// One lane per stereo channel, left is lane 0
	localparam int NUM_LANES = 2;

	// Headroom above the 16-bit sources so four terms can be summed
	localparam int SUM_GUARD = 2;

	////////////////////////////////////////////////////////////
	// Sample widths
	////////////////////////////////////////////////////////////

	// Two's-complement source sample (CD, PSG, ADPCM)
	typedef logic signed [15:0] src_sample_t;

	// Sum of all sources, wraps at this width
	typedef logic signed [15+SUM_GUARD:0] mix_sum_t;

	// Channel level, bit 15 is the sign
	typedef logic [15:0] level_t;

endpackage
